/* sim.f */
common/csr_pkg.sv
hw/credit_fifo.sv
csr/csr_decode.sv
csr/csr_regfile.sv
hw/sys_issue.sv
hw/sys_exec_top.sv
tests/sys_exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f sim.f --top-module sys_exec_tb \
    -Mdir obj_dir -o sys_exec_sim

./obj_dir/sys_exec_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without a reported failure"

/* tests/sys_exec_tb.sv */
`default_nettype none

module sys_exec_tb import csr_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int REQ_DEPTH    = 4;
    localparam int RESP_CREDITS = 2;
    localparam int NUM_REQ      = 400;
    localparam int TIMEOUT      = NUM_REQ * 8 + 200;

    logic      clk         = 1'b0;
    logic      rst         = 1'b0;
    logic      req_valid   = 1'b0;
    sys_req_t  req         = '0;
    logic      resp_credit = 1'b0;
    logic      req_credit;
    logic      resp_valid;
    sys_resp_t resp;

    int seed        = 74;
    int errors      = 0;
    int cycle       = 0;
    int sent        = 0;
    int recv_count  = 0;
    int req_credits = REQ_DEPTH; // Sender side of the request channel.
    int outstanding = 0;         // Responses not yet credited back.

    sys_req_t  req_mem [NUM_REQ];
    sys_resp_t exp_q [$];
    int        credit_due [$];

    // Reference copies of the machine CSRs.
    xlen_t m_mstatus = '0;
    xlen_t m_mtvec   = '0;
    xlen_t m_mepc    = '0;
    xlen_t m_mcause  = '0;

    sys_exec_top uut (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .resp_credit (resp_credit)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic xlen_t model_read(input csr_addr_t addr);
        case (addr)
            12'h300: return m_mstatus;
            12'h305: return m_mtvec;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            default: return '0; // Unknown CSR reads as zero.
        endcase
    endfunction

    task automatic model_write(input csr_addr_t addr, input xlen_t value);
        case (addr)
            12'h300: m_mstatus = value;
            12'h305: m_mtvec   = value;
            12'h341: m_mepc    = value;
            12'h342: m_mcause  = value;
            default: ;
        endcase
    endtask

    // Predicts one response and advances the CSR model.
    task automatic model_exec(input sys_req_t r, output sys_resp_t e);
        logic [2:0] f3;
        xlen_t      opnd;
        xlen_t      old;
        xlen_t      nv;
        f3 = r.instr[14:12];
        e = '0;
        e.tag = r.tag;
        e.rd  = r.instr[11:7];
        if (r.instr == 32'h0000_0073) begin
            e.redirect    = 1'b1;
            e.redirect_pc = m_mtvec;
            m_mepc        = r.pc;
            m_mcause      = 64'd11;
        end else if (r.instr == 32'h3020_0073) begin
            e.redirect    = 1'b1;
            e.redirect_pc = m_mepc;
        end else if (r.instr[6:0] == 7'h73 && f3[1:0] != 2'b00) begin
            opnd = f3[2] ? {59'd0, r.instr[19:15]} : r.rs1_data;
            old  = model_read(r.instr[31:20]);
            case (f3[1:0])
                2'b01:   nv = opnd;
                2'b10:   nv = old | opnd;
                default: nv = old & ~opnd;
            endcase
            model_write(r.instr[31:20], nv);
            e.rd_we   = (r.instr[11:7] != 5'd0);
            e.rd_data = old;
        end
    endtask

    function automatic instr_t csr_instr(input logic [2:0] f3, input csr_addr_t addr,
                                         input logic [4:0] rs1, input reg_idx_t rd);
        return {addr, rs1, f3, rd, 7'h73};
    endfunction

    function automatic csr_addr_t known_addr(input int sel);
        case (sel)
            0:       return 12'h300;
            1:       return 12'h305;
            2:       return 12'h341;
            default: return 12'h342;
        endcase
    endfunction

    task automatic make_request(input int i, output sys_req_t r);
        int         kind;
        int         k3;
        logic [2:0] f3;
        csr_addr_t  addr;
        logic [4:0] rs1;
        reg_idx_t   rd;
        instr_t     w;
        r.tag      = tag_t'(i);
        r.pc       = {$random(seed), $random(seed)};
        r.rs1_data = {$random(seed), $random(seed)};
        kind = int'({$random(seed)} % 100);
        k3   = int'({$random(seed)} % 6);
        f3   = (k3 < 3) ? 3'(k3 + 1) : 3'(k3 + 2);
        addr = known_addr(int'({$random(seed)} % 4));
        if ({$random(seed)} % 10 == 0) begin
            addr = csr_addr_t'($random(seed)); // Mostly unknown addresses.
        end
        rs1 = 5'($random(seed));
        rd  = 5'($random(seed));
        w   = $random(seed);
        if (w[6:0] == 7'h73) begin
            w[0] = 1'b0;
        end
        if (i < 4) begin
            r.instr = csr_instr(3'b110, known_addr(i), 5'd0, rd | 5'd1); // Reads after reset.
        end else if (i == 4) begin
            r.instr = csr_instr(3'b001, 12'h7c0, rs1, rd);
        end else if (i == 5) begin
            r.instr = csr_instr(3'b110, 12'h7c0, 5'd0, rd | 5'd1);
        end else if (i >= NUM_REQ - 4) begin
            r.instr = csr_instr(3'b110, known_addr(i - (NUM_REQ - 4)), 5'd0, rd | 5'd1);
        end else if (kind < 70) begin
            r.instr = csr_instr(f3, addr, rs1, rd);
        end else if (kind < 80) begin
            r.instr = 32'h0000_0073;
        end else if (kind < 90) begin
            r.instr = 32'h3020_0073;
        end else begin
            r.instr = w;
        end
    endtask

    task automatic compare_resp(input sys_resp_t e);
        check_value($sformatf("resp %0d tag", recv_count), 64'(e.tag), 64'(resp.tag));
        check_value($sformatf("resp %0d rd_we", recv_count), 64'(e.rd_we), 64'(resp.rd_we));
        check_value($sformatf("resp %0d redirect", recv_count),
                    64'(e.redirect), 64'(resp.redirect));
        if (e.rd_we) begin
            check_value($sformatf("resp %0d rd", recv_count), 64'(e.rd), 64'(resp.rd));
            check_value($sformatf("resp %0d rd_data", recv_count), e.rd_data, resp.rd_data);
        end
        if (e.redirect) begin
            check_value($sformatf("resp %0d redirect_pc", recv_count),
                        e.redirect_pc, resp.redirect_pc);
        end
    endtask

    initial begin
        sys_req_t  r;
        sys_resp_t e;
        logic      give;
        int        idx;
        for (int i = 0; i < NUM_REQ; i++) begin
            make_request(i, r);
            model_exec(r, e);
            req_mem[i] = r;
            exp_q.push_back(e);
        end
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        while (!(recv_count == NUM_REQ && credit_due.size() == 0) && cycle < TIMEOUT) begin
            @(posedge clk);
            cycle++;
            if (req_credit) begin
                req_credits++;
            end
            if (req_credits > REQ_DEPTH) begin
                $display("Request credits grew past the queue depth at cycle %0d", cycle);
                errors++;
            end
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Response with tag %0d arrived with nothing expected", resp.tag);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    compare_resp(e);
                end
                recv_count++;
                outstanding++;
                if (outstanding > RESP_CREDITS) begin
                    $display("Too many uncredited responses at cycle %0d", cycle);
                    errors++;
                end
                credit_due.push_back(cycle + int'({$random(seed)} % 6));
            end
            // At most one credit pulse per cycle.
            give = 1'b0;
            idx  = 0;
            for (int k = 0; k < credit_due.size(); k++) begin
                if (!give && credit_due[k] <= cycle) begin
                    give = 1'b1;
                    idx  = k;
                end
            end
            if (give) begin
                credit_due.delete(idx);
                outstanding--;
            end
            resp_credit <= give;
            if (sent < NUM_REQ && req_credits > 0 && ({$random(seed)} % 4) != 0) begin
                req_valid <= 1'b1;
                req       <= req_mem[sent];
                sent++;
                req_credits--;
            end else begin
                req_valid <= 1'b0;
            end
        end
        if (recv_count != NUM_REQ) begin
            $display("Timeout after %0d cycles with %0d of %0d responses received",
                     cycle, recv_count, NUM_REQ);
            errors++;
        end else begin
            check_value("final request credits", 64'(REQ_DEPTH), 64'(req_credits));
        end
        $display("Errors: %0d, responses checked: %0d of %0d", errors, recv_count, NUM_REQ);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/sys_exec_top.sv */
`default_nettype none

module sys_exec_top import csr_pkg::*; #(
    parameter int REQ_DEPTH    = 4,
    parameter int RESP_CREDITS = 2
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       req_valid,
    input  sys_req_t  req,
    output logic      req_credit,
    output logic      resp_valid,
    output sys_resp_t resp,
    input  wire       resp_credit
);

    sys_req_t head;
    logic     empty;
    logic     pop;
    logic     commit;
    csr_cmd_t cmd;
    xlen_t    rdata;
    xlen_t    mtvec;
    xlen_t    mepc;

    credit_fifo #(
        .REQ_DEPTH (REQ_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (req_valid),
        .push_data (req),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .credit    (req_credit)
    );

    csr_decode u_decode (
        .instr (head.instr),
        .cmd   (cmd)
    );

    csr_regfile u_csr (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .commit   (commit),
        .pc       (head.pc),
        .rs1_data (head.rs1_data),
        .rdata    (rdata),
        .mtvec    (mtvec),
        .mepc     (mepc)
    );

    sys_issue #(
        .RESP_CREDITS (RESP_CREDITS)
    ) u_issue (
        .clk         (clk),
        .rst         (rst),
        .empty       (empty),
        .head        (head),
        .cmd         (cmd),
        .rdata       (rdata),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .pop         (pop),
        .commit      (commit),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule

`default_nettype wire

/* hw/sys_issue.sv */
`default_nettype none

module sys_issue import csr_pkg::*; #(
    parameter int RESP_CREDITS = 2
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       empty,
    input  sys_req_t  head,
    input  csr_cmd_t  cmd,
    input  xlen_t     rdata,
    input  xlen_t     mtvec,
    input  xlen_t     mepc,
    output logic      pop,
    output logic      commit,
    input  wire       resp_credit,
    output logic      resp_valid,
    output sys_resp_t resp
);

    localparam int CNT_W = $clog2(RESP_CREDITS + 1);

    logic [CNT_W-1:0] credits;
    sys_resp_t        resp_d;

    assign pop    = !empty && (credits != '0);
    assign commit = pop;

    always_ff @(posedge clk) begin
        if (!rst) begin
            credits <= CNT_W'(RESP_CREDITS);
        end else begin
            case ({pop, resp_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_comb begin
        resp_d.tag         = head.tag;
        resp_d.rd          = cmd.rd;
        resp_d.rd_we       = 1'b0;
        resp_d.rd_data     = '0;
        resp_d.redirect    = 1'b0;
        resp_d.redirect_pc = '0;

        case (cmd.op)
            OP_WRITE, OP_SET, OP_CLEAR: begin
                resp_d.rd_we   = (cmd.rd != '0);
                resp_d.rd_data = rdata;
            end
            OP_ECALL: begin
                resp_d.redirect    = 1'b1;
                resp_d.redirect_pc = mtvec; // Trap vector before this commit.
            end
            OP_MRET: begin
                resp_d.redirect    = 1'b1;
                resp_d.redirect_pc = mepc;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            resp <= resp_d;
        end
    end

endmodule

`default_nettype wire

/* csr/csr_regfile.sv */
`default_nettype none

module csr_regfile import csr_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  csr_cmd_t cmd,
    input  wire      commit,
    input  xlen_t    pc,
    input  xlen_t    rs1_data,
    output xlen_t    rdata,
    output xlen_t    mtvec,
    output xlen_t    mepc
);

    xlen_t mstatus_q;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;

    xlen_t mstatus_d;
    xlen_t mtvec_d;
    xlen_t mepc_d;
    xlen_t mcause_d;

    xlen_t operand;
    xlen_t wdata;

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

    // Old value of the addressed CSR.
    always_comb begin
        case (cmd.addr)
            CSR_MSTATUS: rdata = mstatus_q;
            CSR_MTVEC:   rdata = mtvec_q;
            CSR_MEPC:    rdata = mepc_q;
            CSR_MCAUSE:  rdata = mcause_q;
            default:     rdata = '0;
        endcase
    end

    assign operand = cmd.use_imm ? xlen_t'(cmd.zimm) : rs1_data;

    always_comb begin
        case (cmd.op)
            OP_WRITE: wdata = operand;
            OP_SET:   wdata = rdata | operand;
            OP_CLEAR: wdata = rdata & ~operand;
            default:  wdata = rdata;
        endcase
    end

    always_comb begin
        mstatus_d = mstatus_q;
        mtvec_d   = mtvec_q;
        mepc_d    = mepc_q;
        mcause_d  = mcause_q;

        if (commit) begin
            case (cmd.op)
                OP_WRITE, OP_SET, OP_CLEAR: begin
                    case (cmd.addr)
                        CSR_MSTATUS: mstatus_d = wdata;
                        CSR_MTVEC:   mtvec_d   = wdata;
                        CSR_MEPC:    mepc_d    = wdata;
                        CSR_MCAUSE:  mcause_d  = wdata;
                        default: begin
                            // Unknown address, write dropped.
                        end
                    endcase
                end
                OP_ECALL: begin
                    mepc_d   = pc;
                    mcause_d = CAUSE_ECALL_M;
                end
                default: begin
                    // MRET and none leave the CSRs alone.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else begin
            mstatus_q <= mstatus_d;
            mtvec_q   <= mtvec_d;
            mepc_q    <= mepc_d;
            mcause_q  <= mcause_d;
        end
    end

endmodule

`default_nettype wire

/* csr/csr_decode.sv */
`default_nettype none

module csr_decode import csr_pkg::*; (
    input  instr_t   instr,
    output csr_cmd_t cmd
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        cmd.op      = OP_NONE;
        cmd.addr    = instr[31:20];
        cmd.use_imm = instr[14];  // High funct3 bit selects the immediate forms.
        cmd.zimm    = instr[19:15];
        cmd.rd      = instr[11:7];

        if (opcode == OPCODE_SYSTEM) begin
            case (funct3)
                F3_CSRRW, F3_CSRRWI: begin
                    cmd.op = OP_WRITE;
                end
                F3_CSRRS, F3_CSRRSI: begin
                    cmd.op = OP_SET;
                end
                F3_CSRRC, F3_CSRRCI: begin
                    cmd.op = OP_CLEAR;
                end
                F3_PRIV: begin
                    // Only exact encodings count.
                    if (instr == INSTR_ECALL) begin
                        cmd.op = OP_ECALL;
                    end else if (instr == INSTR_MRET) begin
                        cmd.op = OP_MRET;
                    end
                end
                default: begin
                    cmd.op = OP_NONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/credit_fifo.sv */
`default_nettype none

module credit_fifo import csr_pkg::*; #(
    parameter int REQ_DEPTH = 4
) (
    input  wire      clk,
    input  wire      rst,
    input  wire      push,
    input  sys_req_t push_data,
    input  wire      pop,
    output sys_req_t head,
    output logic     empty,
    output logic     credit
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    sys_req_t mem [REQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head   = mem[rd_ptr];
    assign empty  = (count == '0);
    assign credit = pop; // One credit back per entry removed.

    // Sender credits guarantee a free slot on every push.
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == PTR_W'(REQ_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(REQ_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

/* common/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  tag_t;

    // Machine CSR addresses.
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    localparam xlen_t CAUSE_ECALL_M = 64'd11; // Environment call from M-mode.

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // funct3 of the SYSTEM opcode.
    localparam logic [2:0] F3_PRIV   = 3'b000;
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // Full encodings, all other fields zero.
    localparam instr_t INSTR_ECALL = 32'h0000_0073;
    localparam instr_t INSTR_MRET  = 32'h3020_0073;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_WRITE,
        OP_SET,
        OP_CLEAR,
        OP_ECALL,
        OP_MRET
    } csr_op_e;

    typedef struct packed {
        instr_t instr;
        xlen_t  pc;
        xlen_t  rs1_data;
        tag_t   tag;
    } sys_req_t;

    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        logic      use_imm;
        logic [4:0] zimm;     // rs1 field of the immediate forms.
        reg_idx_t  rd;
    } csr_cmd_t;

    typedef struct packed {
        tag_t     tag;
        reg_idx_t rd;
        logic     rd_we;
        xlen_t    rd_data;
        logic     redirect;
        xlen_t    redirect_pc;
    } sys_resp_t;

endpackage

`default_nettype wire
